/* flist.f */
+incdir+include
rtl/ppu_pkg.sv
rtl/vga_timing.sv
rtl/ppu_cpu_port.sv
rtl/ppu_mem.sv
rtl/pixel_out.sv
rtl/ppu_top.sv
tb/tb_ppu.sv

/* include/ppu_model.svh */
`ifndef PPU_MODEL_SVH
`define PPU_MODEL_SVH

// reference state of the CPU side, updated in bus order by the testbench
logic [7:0] m_ctrl;
logic m_toggle;
logic [13:0] m_addr;
logic [7:0] m_buf;
logic [7:0] m_rdata;
logic m_vblank;
logic [7:0] m_nt [2**`NT_ADDR_W];
logic [5:0] m_pal [`PAL_ENTRIES];

function automatic void reset_model();
	m_ctrl = '0;
	m_toggle = 1'b0;
	m_addr = '0;
	m_buf = '0;
	m_rdata = '0;
	m_vblank = 1'b0;
	for (int i = 0; i < `PAL_ENTRIES; i++) begin
		m_pal[i] = '0;
	end
endfunction

function automatic logic [13:0] addr_step();
	return m_ctrl[2] ? 14'd32 : 14'd1;
endfunction

function automatic int pal_index(logic [13:0] addr);
	if (addr[4:0] == 5'h10) begin
		return 0; // sprite backdrop shares entry 0
	end
	return int'(addr[4:0]);
endfunction

function automatic logic [7:0] mem_load(logic [13:0] addr);
	if (addr < 14'h2000) begin
		return 8'h00;
	end
	if (addr[13:8] == 6'h3F) begin
		return {2'b00, m_pal[pal_index(addr)]};
	end
	return m_nt[addr[10:0]]; // vertical mirroring ignores bit 11
endfunction

function automatic void mem_store(logic [13:0] addr, logic [7:0] data);
	if (addr[13:8] == 6'h3F) begin
		m_pal[pal_index(addr)] = data[5:0];
	end else if (addr >= 14'h2000) begin
		m_nt[addr[10:0]] = data;
	end
endfunction

function automatic void predict_write(reg_sel_t sel, logic [7:0] data);
	case (sel)
		CTRL: m_ctrl = data;
		ADDR: begin
			if (!m_toggle) begin
				m_addr[13:8] = data[5:0];
			end else begin
				m_addr[7:0] = data;
			end
			m_toggle = !m_toggle;
		end
		DATA: begin
			mem_store(m_addr, data);
			m_addr = m_addr + addr_step();
		end
		default: ;
	endcase
endfunction

function automatic logic [7:0] predict_read(reg_sel_t sel);
	if (sel == STATUS) begin
		m_rdata = {m_vblank, 7'b0};
		m_vblank = 1'b0;
		m_toggle = 1'b0;
	end else if (sel == DATA) begin
		m_rdata = m_buf; // the fetch below only shows up on the next read
		m_buf = mem_load(m_addr);
		m_addr = m_addr + addr_step();
	end
	return m_rdata;
endfunction

function automatic logic [11:0] expected_rgb(logic [5:0] idx);
	logic [23:0] colour;
	colour = MASTER_PALETTE[idx];
	return {colour[23:20], colour[15:12], colour[7:4]};
endfunction

`endif

/* tb/tb_ppu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ppu_settings.svh"

module tb_ppu;

	import ppu_pkg::*;

	localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
	localparam int TIMEOUT_CYCLES = 2 * FRAME_CYCLES + 160_000; // two frames plus register traffic

	logic vga_clk;
	logic rst_n;
	cpu_req_t cpu;
	logic [7:0] rdata;
	logic nmi;
	rgb_t rgb;
	logic hs;
	logic vs;
	int cyc; // cycles since reset release, so it gives the DUT pixel and line
	int total_cycles;

	`include "ppu_model.svh"

	ppu_top i_dut (
		.vga_clk(vga_clk),
		.rst_n(rst_n),
		.cpu(cpu),
		.rdata(rdata),
		.nmi(nmi),
		.rgb(rgb),
		.hs(hs),
		.vs(vs)
	);

	initial begin
		vga_clk = 1'b0;
		forever #50 vga_clk = ~vga_clk;
	end

	always @(posedge vga_clk) begin
		total_cycles <= total_cycles + 1;
		if (rst_n) begin
			cyc <= cyc + 1;
			// the flag follows the frame strobe by one cycle
			if ((cyc + 1) % FRAME_CYCLES == `V_ACTIVE * `H_TOTAL + 1) begin
				m_vblank <= 1'b1;
			end else if ((cyc + 1) % FRAME_CYCLES == 1) begin
				m_vblank <= 1'b0;
			end
		end
	end

	always @(posedge vga_clk) begin
		if (total_cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: no end of test after %0d cycles", total_cycles);
			$display("Some tests failed");
			$fatal(1);
		end
	end

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got === exp) else begin
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	task automatic drive_strobe(input logic wr, input reg_sel_t sel, input logic [7:0] wdata);
		cpu.wr = wr;
		cpu.rd = !wr;
		cpu.sel = sel;
		cpu.wdata = wdata;
		@(negedge vga_clk);
		cpu.wr = 1'b0;
		cpu.rd = 1'b0;
	endtask

	task automatic wait_gap();
		int n;
		n = 3 + int'($urandom % 5); // strobes land 4 to 8 cycles apart
		repeat (n) @(negedge vga_clk);
	endtask

	task automatic write_reg(input reg_sel_t sel, input logic [7:0] data);
		predict_write(sel, data);
		drive_strobe(1'b1, sel, data);
		wait_gap();
	endtask

	task automatic read_check(input reg_sel_t sel, input string what);
		logic [7:0] exp;
		exp = predict_read(sel);
		drive_strobe(1'b0, sel, 8'h00);
		check_value(rdata, exp, what);
		wait_gap();
	endtask

	task automatic set_addr(input logic [13:0] addr);
		write_reg(ADDR, {2'b00, addr[13:8]});
		write_reg(ADDR, addr[7:0]);
	endtask

	task automatic nametable_round();
		logic [13:0] base;
		logic alias_hi;
		int n;
		base = 14'h2000 | 14'($urandom % 2048);
		alias_hi = 1'($urandom % 2);
		n = 4 + int'($urandom % 9);
		write_reg(CTRL, {5'b0, 1'($urandom % 2), 2'b0}); // the step is random and nmi stays off
		set_addr(alias_hi ? (base | 14'h0800) : base);
		for (int i = 0; i < n; i++) begin
			write_reg(DATA, 8'($urandom));
		end
		set_addr(base);
		for (int i = 0; i < n; i++) begin
			read_check(DATA, "nametable read");
		end
	endtask

	task automatic palette_test();
		write_reg(CTRL, 8'h00);
		for (int i = 0; i < 12; i++) begin
			set_addr(14'h3F00 | 14'($urandom % `PAL_ENTRIES));
			write_reg(DATA, 8'($urandom));
		end
		set_addr(14'h3F10);
		write_reg(DATA, 8'($urandom));
		set_addr(14'h3F00);
		for (int i = 0; i < `PAL_ENTRIES; i++) begin
			read_check(DATA, "palette read");
		end
	endtask

	task automatic pattern_test();
		logic [13:0] base;
		base = 14'($urandom % 14'h1F00);
		set_addr(base);
		write_reg(DATA, 8'($urandom));
		set_addr(base);
		for (int i = 0; i < 3; i++) begin
			read_check(DATA, "pattern read");
		end
	endtask

	task automatic backdrop_test();
		int start;
		set_addr(14'h3F00);
		write_reg(DATA, {2'b00, 6'($urandom)});
		start = cyc;
		while (cyc < start + 2 * `H_TOTAL || cyc % `H_TOTAL != `H_ACTIVE / 2
				|| (cyc / `H_TOTAL) % `V_TOTAL >= `V_ACTIVE) begin
			@(negedge vga_clk);
		end
		check_value(rgb, expected_rgb(m_pal[0]), "backdrop colour");
		while (cyc % `H_TOTAL != `H_ACTIVE + 40) begin
			@(negedge vga_clk);
		end
		check_value(rgb, 12'h000, "rgb in horizontal blank");
	endtask

	task automatic vblank_test();
		logic vs_prev;
		logic [7:0] exp;
		int vs_low;
		int n;
		write_reg(CTRL, 8'h80);
		vs_prev = vs;
		@(negedge vga_clk);
		while (!(vs_prev && !vs)) begin
			vs_prev = vs;
			@(negedge vga_clk);
		end
		repeat (2) @(negedge vga_clk);
		check_value(nmi, 1'b1, "nmi in vertical blank");
		exp = predict_read(STATUS);
		drive_strobe(1'b0, STATUS, 8'h00);
		check_value(rdata, 8'h80, "status with vblank set");
		check_value(rdata, exp, "status against model");
		@(negedge vga_clk);
		check_value(nmi, 1'b0, "nmi after status read");
		wait_gap();
		read_check(STATUS, "second status read");
		write_reg(CTRL, 8'h00);
		vs_low = 0;
		n = 0;
		while (cyc < 2 * FRAME_CYCLES + 8) begin // runs through the next vertical blank
			@(negedge vga_clk);
			check_value(nmi, 1'b0, "nmi with control bit 7 clear");
			if (n < FRAME_CYCLES && !vs) begin
				vs_low++;
			end
			n++;
		end
		check_value(vs_low, (`VS_END - `VS_START) * `H_TOTAL, "vs low cycles per frame");
	endtask

	initial begin
		int hs_low;
		reset_model();
		void'($urandom(34891));
		rst_n = 1'b0;
		cpu = '0;
		cyc = 0;
		total_cycles = 0;
		repeat (10) @(negedge vga_clk);
		rst_n = 1'b1;
		check_value(nmi, 1'b0, "nmi after reset");
		check_value(rdata, 8'h00, "rdata after reset");
		check_value(rgb, 12'h000, "rgb after reset");
		check_value(hs, 1'b0, "hs after reset");
		check_value(vs, 1'b0, "vs after reset");
		repeat (2) @(negedge vga_clk);
		hs_low = 0;
		repeat (`H_TOTAL) begin
			@(negedge vga_clk);
			if (!hs) begin
				hs_low++;
			end
		end
		check_value(hs_low, `HS_END - `HS_START, "hs low cycles per line");
		for (int r = 0; r < 8; r++) begin
			nametable_round();
		end
		palette_test();
		pattern_test();
		backdrop_test();
		vblank_test();
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/ppu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ppu_top (
	input wire logic vga_clk,
	input wire logic rst_n,
	input wire ppu_pkg::cpu_req_t cpu,
	output logic [7:0] rdata,
	output logic nmi,
	output ppu_pkg::rgb_t rgb,
	output logic hs,
	output logic vs
);

	import ppu_pkg::*;

	vga_pos_t pos;
	mem_req_t mem;
	logic vblank_start;
	logic vblank_end;
	logic [7:0] mem_rdata;
	logic [7:0] backdrop;

	vga_timing i_vga_timing (
		.vga_clk(vga_clk),
		.rst_n(rst_n),
		.pos(pos),
		.hs(hs),
		.vs(vs),
		.vblank_start(vblank_start),
		.vblank_end(vblank_end)
	);

	ppu_cpu_port i_cpu_port (
		.vga_clk(vga_clk),
		.rst_n(rst_n),
		.cpu(cpu),
		.vblank_start(vblank_start),
		.vblank_end(vblank_end),
		.mem_rdata(mem_rdata),
		.mem(mem),
		.rdata(rdata),
		.nmi(nmi)
	);

	ppu_mem i_mem (
		.vga_clk(vga_clk),
		.rst_n(rst_n),
		.mem(mem),
		.mem_rdata(mem_rdata),
		.backdrop(backdrop)
	);

	pixel_out i_pixel_out (
		.vga_clk(vga_clk),
		.rst_n(rst_n),
		.pos(pos),
		.backdrop(backdrop),
		.rgb(rgb)
	);

endmodule

`default_nettype wire

/* rtl/pixel_out.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_out (
	input wire logic vga_clk,
	input wire logic rst_n,
	input wire ppu_pkg::vga_pos_t pos,
	input wire logic [7:0] backdrop,
	output ppu_pkg::rgb_t rgb
);

	import ppu_pkg::*;

	logic [23:0] colour;
	logic blank;
	rgb_t rgb_next;

	// the DAC only takes four bits per channel
	always_comb begin
		colour = MASTER_PALETTE[backdrop[5:0]];
		rgb_next.r = colour[23:20];
		rgb_next.g = colour[15:12];
		rgb_next.b = colour[7:4];
	end

	assign blank = pos.h_blank | pos.v_blank; // monitors expect black outside the active area

	always_ff @(posedge vga_clk or negedge rst_n) begin
		if (!rst_n) begin
			rgb <= '0;
		end else if (blank) begin
			rgb <= '0;
		end else begin
			rgb <= rgb_next;
		end
	end

endmodule

`default_nettype wire

/* rtl/ppu_mem.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ppu_settings.svh"

module ppu_mem (
	input wire logic vga_clk,
	input wire logic rst_n,
	input wire ppu_pkg::mem_req_t mem,
	output logic [7:0] mem_rdata,
	output logic [7:0] backdrop
);

	localparam int PAL_IDX_W = $clog2(`PAL_ENTRIES);

	logic [7:0] nt_ram [2**`NT_ADDR_W];
	logic [5:0] pal_ram [`PAL_ENTRIES];
	logic [`NT_ADDR_W-1:0] nt_idx;
	logic [PAL_IDX_W-1:0] pal_idx;
	logic nt_sel;
	logic pal_sel;
	logic [7:0] nt_q;
	logic [5:0] pal_q;
	logic rd_nt;
	logic rd_pal;

	// everything below $2000 is pattern space and reads as zero
	assign pal_sel = (mem.addr[13:8] == 6'h3F);
	assign nt_sel = mem.addr[13] && !pal_sel;
	assign nt_idx = mem.addr[`NT_ADDR_W-1:0]; // bit 11 dropped, so $2800 lands on $2000
	assign pal_idx = (mem.addr[4:0] == 5'h10) ? '0 : mem.addr[PAL_IDX_W-1:0];

	always_ff @(posedge vga_clk) begin
		if (nt_sel && mem.wr) begin
			nt_ram[nt_idx] <= mem.wdata;
		end
		if (mem.rd) begin
			nt_q <= nt_ram[nt_idx];
		end
	end

	always_ff @(posedge vga_clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `PAL_ENTRIES; i++) begin
				pal_ram[i] <= '0;
			end
		end else if (pal_sel && mem.wr) begin
			pal_ram[pal_idx] <= mem.wdata[5:0]; // the master palette has 64 colours
		end
	end

	always_ff @(posedge vga_clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_nt <= 1'b0;
			rd_pal <= 1'b0;
			pal_q <= '0;
			backdrop <= '0;
		end else begin
			if (mem.rd) begin
				rd_nt <= nt_sel;
				rd_pal <= pal_sel;
				pal_q <= pal_ram[pal_idx];
			end
			backdrop <= {2'b00, pal_ram[0]};
		end
	end

	always_comb begin
		if (rd_nt) begin
			mem_rdata = nt_q;
		end else if (rd_pal) begin
			mem_rdata = {2'b00, pal_q};
		end else begin
			mem_rdata = 8'h00;
		end
	end

endmodule

`default_nettype wire

/* rtl/ppu_cpu_port.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ppu_settings.svh"

module ppu_cpu_port (
	input wire logic vga_clk,
	input wire logic rst_n,
	input wire ppu_pkg::cpu_req_t cpu,
	input wire logic vblank_start,
	input wire logic vblank_end,
	input wire logic [7:0] mem_rdata,
	output ppu_pkg::mem_req_t mem,
	output logic [7:0] rdata,
	output logic nmi
);

	import ppu_pkg::*;

	port_state_t state;
	logic [7:0] ctrl;
	logic toggle;
	logic [13:0] vaddr;
	logic [7:0] rd_buf;
	logic [7:0] wr_data;
	logic vblank_flag;
	logic [13:0] step;
	logic cpu_strobe;
	logic status_rd;

	assign step = ctrl[2] ? 14'd32 : 14'd1; // ctrl bit 2 walks down a nametable column
	assign cpu_strobe = cpu.wr | cpu.rd;
	assign status_rd = (state == IDLE) && cpu.rd && (cpu.sel == STATUS);

	always_ff @(posedge vga_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			ctrl <= '0;
			toggle <= 1'b0;
			vaddr <= '0;
			rd_buf <= '0;
			rdata <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (cpu.wr) begin
						case (cpu.sel)
							CTRL: ctrl <= cpu.wdata;
							ADDR: begin
								if (!toggle) begin
									vaddr[13:8] <= cpu.wdata[5:0]; // high byte goes first
								end else begin
									vaddr[7:0] <= cpu.wdata;
								end
								toggle <= !toggle;
							end
							DATA: state <= MEM_WRITE;
							default: ; // mask, OAM and scroll writes have no effect here
						endcase
					end else if (cpu.rd) begin
						case (cpu.sel)
							STATUS: begin
								rdata <= {vblank_flag, 7'b0};
								toggle <= 1'b0;
							end
							DATA: begin
								rdata <= rd_buf; // the CPU sees the previous fetch
								state <= BUF_FETCH;
							end
							default: ;
						endcase
					end
				end
				MEM_WRITE: begin
					vaddr <= vaddr + step;
					state <= IDLE;
				end
				BUF_FETCH: state <= BUF_LOAD;
				BUF_LOAD: begin
					rd_buf <= mem_rdata;
					vaddr <= vaddr + step;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge vga_clk) begin
		if (cpu.wr && (cpu.sel == DATA)) begin
			wr_data <= cpu.wdata;
		end
	end

	// a vblank that begins on the same cycle as a status read stays visible
	always_ff @(posedge vga_clk or negedge rst_n) begin
		if (!rst_n) begin
			vblank_flag <= 1'b0;
			nmi <= 1'b0;
		end else begin
			if (vblank_start) begin
				vblank_flag <= 1'b1;
			end else if (vblank_end || status_rd) begin
				vblank_flag <= 1'b0;
			end
			nmi <= vblank_flag & ctrl[7];
		end
	end

	always_comb begin
		mem.rd = (state == BUF_FETCH);
		mem.wr = (state == MEM_WRITE);
		mem.addr = vaddr;
		mem.wdata = wr_data;
	end

	a_strobe_idle: assert property (@(posedge vga_clk) disable iff (!rst_n)
		cpu_strobe |-> (state == IDLE));

	a_strobe_gap: assert property (@(posedge vga_clk) disable iff (!rst_n)
		cpu_strobe |=> !cpu_strobe [*(`STROBE_GAP - 1)]);

endmodule

`default_nettype wire

/* rtl/vga_timing.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ppu_settings.svh"

module vga_timing (
	input wire logic vga_clk,
	input wire logic rst_n,
	output ppu_pkg::vga_pos_t pos,
	output logic hs,
	output logic vs,
	output logic vblank_start,
	output logic vblank_end
);

	logic [9:0] h_cnt;
	logic [9:0] v_cnt;
	logic [9:0] h_next;
	logic [9:0] v_next;

	always_comb begin
		h_next = h_cnt + 10'd1;
		v_next = v_cnt;
		if (h_cnt == `H_TOTAL - 1) begin
			h_next = '0;
			if (v_cnt == `V_TOTAL - 1) begin
				v_next = '0;
			end else begin
				v_next = v_cnt + 10'd1;
			end
		end
	end

	// outputs are decoded from the next count so they line up with h_cnt and v_cnt
	always_ff @(posedge vga_clk or negedge rst_n) begin
		if (!rst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
			hs <= 1'b0;
			vs <= 1'b0;
			vblank_start <= 1'b0;
			vblank_end <= 1'b0;
		end else begin
			h_cnt <= h_next;
			v_cnt <= v_next;
			hs <= !(h_next >= `HS_START && h_next < `HS_END); // sync pulses are active low
			vs <= !(v_next >= `VS_START && v_next < `VS_END);
			vblank_start <= (h_next == '0) && (v_next == `V_ACTIVE);
			vblank_end <= (h_next == '0) && (v_next == '0);
		end
	end

	always_comb begin
		pos.x = h_cnt;
		pos.y = v_cnt;
		pos.h_blank = (h_cnt >= `H_ACTIVE);
		pos.v_blank = (v_cnt >= `V_ACTIVE);
	end

	a_count_range: assert property (@(posedge vga_clk) disable iff (!rst_n)
		(h_cnt < `H_TOTAL) && (v_cnt < `V_TOTAL));

endmodule

`default_nettype wire

/* rtl/ppu_pkg.sv */
`default_nettype none

package ppu_pkg;

	typedef enum logic [2:0] {
		CTRL,
		MASK,
		STATUS,
		OAM_ADDR,
		OAM_DATA,
		SCROLL,
		ADDR,
		DATA
	} reg_sel_t;

	typedef enum logic [1:0] {
		IDLE,
		MEM_WRITE,
		BUF_FETCH,
		BUF_LOAD
	} port_state_t;

	typedef struct packed {
		logic wr;
		logic rd;
		reg_sel_t sel;
		logic [7:0] wdata;
	} cpu_req_t;

	typedef struct packed {
		logic rd;
		logic wr;
		logic [13:0] addr;
		logic [7:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
		logic h_blank;
		logic v_blank;
	} vga_pos_t;

	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb_t;

	// 8 bits per channel, red in the top byte
	parameter logic [23:0] MASTER_PALETTE [64] = '{
		24'h545454, 24'h001E74, 24'h081090, 24'h300088,
		24'h440064, 24'h5C0030, 24'h540400, 24'h3C1800,
		24'h202A00, 24'h083A00, 24'h004000, 24'h003C00,
		24'h00323C, 24'h000000, 24'h000000, 24'h000000,

		24'h989698, 24'h084CC4, 24'h3032EC, 24'h5C1EE4,
		24'h8814B0, 24'hA01464, 24'h982220, 24'h783C00,
		24'h545A00, 24'h287200, 24'h087C00, 24'h007628,
		24'h006678, 24'h000000, 24'h000000, 24'h000000,

		24'hECEEEC, 24'h4C9AEC, 24'h787CEC, 24'hB062EC,
		24'hE454EC, 24'hEC58B4, 24'hEC6A64, 24'hD48820,
		24'hA0AA00, 24'h74C400, 24'h4CD020, 24'h38CC6C,
		24'h38B4CC, 24'h3C3C3C, 24'h000000, 24'h000000,

		24'hECEEEC, 24'hA8CCEC, 24'hBCBCEC, 24'hD4B2EC,
		24'hECAEEC, 24'hECAED4, 24'hECB4B0, 24'hE4C490,
		24'hCCD278, 24'hB4DE78, 24'hA8E290, 24'h98E2B4,
		24'hA0D6E4, 24'hA0A2A0, 24'h000000, 24'h000000
	};

endpackage

`default_nettype wire

/* include/ppu_settings.svh */
`ifndef PPU_SETTINGS_SVH
`define PPU_SETTINGS_SVH

// 640x480 VGA, horizontal counts in pixels
`define H_TOTAL 800
`define H_ACTIVE 640
`define HS_START 656
`define HS_END 752

// vertical counts in lines
`define V_TOTAL 525
`define V_ACTIVE 480
`define VS_START 490
`define VS_END 492

// 2 KB nametable RAM, two screens with vertical mirroring
`define NT_ADDR_W 11

// four background and four sprite palettes of four entries each
`define PAL_ENTRIES 32

// the CPU side runs without back-pressure, so strobes must leave the FSM room to finish
`define STROBE_GAP 4

`endif
